// File: exu_subsys.f
source/exu_pkg.sv
source/exu_alu.sv
source/exu_branch_sys.sv
source/exu_csr.sv
source/exu_perf_counter.sv
source/exu_ctrl_fsm.sv
source/exu_top.sv
testbench/tb_exu.sv

// File: testbench/tb_exu.sv
`timescale 1ns/1ps

module tb_exu import exu_pkg::*; ();

  localparam logic [XLEN-1:0] MTVEC_INIT = 32'h0000_0100;
  localparam int WAIT_LIMIT = 40;
  localparam logic [2:0] SRC_FIXED  = 3'd0;
  localparam logic [2:0] SRC_CYC_LO = 3'd1;
  localparam logic [2:0] SRC_CYC_HI = 3'd2;
  localparam logic [2:0] SRC_RET_LO = 3'd3;
  localparam logic [2:0] SRC_RET_HI = 3'd4;
  localparam logic [3:0] BR_OPS [6] = '{ALU_SUB, ALU_XOR, ALU_SLT, ALU_SLTU, ALU_SLE, ALU_SLEU};
  localparam logic [2:0] CSR_F3S [6] = '{F3_CSRRW, F3_CSRRS, F3_CSRRC,
                                         F3_CSRRWI, F3_CSRRSI, F3_CSRRCI};
  localparam logic [11:0] CSR_ADDRS [8] = '{CSR_MSTATUS, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE,
                                            CSR_MCYCLE, CSR_MCYCLEH, CSR_MINSTRET, CSR_MINSTRETH};

  logic            clk, rst;
  logic [31:0]     inst_i, inst_o;
  logic [XLEN-1:0] pc_i, imm_i, op1_i, op2_i, opj_i, pc_o, reg_wdata_o, npc_o;
  logic [3:0]      alu_op_i;
  logic [4:0]      rd_i, rd_o;
  logic            ren_i, wen_i, system_i, csr_wen_i, ecall_i, mret_i, ebreak_i;
  logic            prev_valid_i, ready_o, valid_o, next_ready_i;
  logic            redirect_o, branch_retire_o, ebreak_o;
  logic            lsu_req_o, lsu_we_o, lsu_rvalid_i, lsu_wready_i;
  logic [XLEN-1:0] lsu_addr_o, lsu_wdata_o, lsu_rdata_i;

  // reference model state
  logic [XLEN-1:0] m_mstatus, m_mtvec, m_mepc, m_mcause, cur_pc;
  logic [XLEN-1:0] ref_mem [0:63];
  logic [XLEN-1:0] mem [0:63];
  logic [XLEN-1:0] exp_fixed, exp_wdata, exp_npc, exp_addr, exp_store, exp_pc;
  logic [31:0]     exp_inst;
  logic [4:0]      exp_rd;
  logic [2:0]      exp_src;
  logic            exp_redirect, exp_retire, exp_we, exp_ebreak, handoff;
  logic [63:0]     cycle_cnt, handoff_cnt, capture_cnt;
  int              errors = 0;

  exu_top #(.CNT_W(64), .MTVEC_RESET(MTVEC_INIT)) exu_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  assign handoff = valid_o && next_ready_i;

  always @(posedge clk) begin
    if (rst) begin
      cycle_cnt   <= '0;
      handoff_cnt <= '0;
      capture_cnt <= '0;
    end else begin
      cycle_cnt <= cycle_cnt + 1;
      if (handoff) handoff_cnt <= handoff_cnt + 1;
      if (prev_valid_i && ready_o) capture_cnt <= capture_cnt + 1;
    end
  end

  // counter reads are only known at the handoff edge
  always_comb begin
    case (exp_src)
      SRC_CYC_LO: exp_wdata = cycle_cnt[31:0];
      SRC_CYC_HI: exp_wdata = cycle_cnt[63:32];
      SRC_RET_LO: exp_wdata = handoff_cnt[31:0];
      SRC_RET_HI: exp_wdata = handoff_cnt[63:32];
      default: exp_wdata = exp_fixed;
    endcase
  end

  task automatic report_mismatch(input string name, input logic [XLEN-1:0] got,
                                 input logic [XLEN-1:0] exp);
    errors++;
    $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("at %0t: %s", $time, what);
  endtask

  a_wdata: assert property (@(posedge clk) disable iff (rst)
    handoff |-> reg_wdata_o == exp_wdata)
    else report_mismatch("reg_wdata_o", $sampled(reg_wdata_o), $sampled(exp_wdata));
  a_redirect: assert property (@(posedge clk) disable iff (rst)
    handoff |-> redirect_o == exp_redirect)
    else report_mismatch("redirect_o", $sampled(redirect_o), $sampled(exp_redirect));
  a_npc: assert property (@(posedge clk) disable iff (rst)
    handoff && exp_redirect |-> npc_o == exp_npc)
    else report_mismatch("npc_o", $sampled(npc_o), $sampled(exp_npc));
  a_retire: assert property (@(posedge clk) disable iff (rst)
    handoff |-> branch_retire_o == exp_retire)
    else report_mismatch("branch_retire_o", $sampled(branch_retire_o), $sampled(exp_retire));
  a_rd: assert property (@(posedge clk) disable iff (rst)
    handoff |-> rd_o == exp_rd)
    else report_mismatch("rd_o", $sampled(rd_o), $sampled(exp_rd));
  a_pc: assert property (@(posedge clk) disable iff (rst)
    handoff |-> pc_o == exp_pc)
    else report_mismatch("pc_o", $sampled(pc_o), $sampled(exp_pc));
  a_inst: assert property (@(posedge clk) disable iff (rst)
    handoff |-> inst_o == exp_inst)
    else report_mismatch("inst_o", $sampled(inst_o), $sampled(exp_inst));
  a_ebreak: assert property (@(posedge clk) disable iff (rst)
    handoff |-> ebreak_o == exp_ebreak)
    else report_mismatch("ebreak_o", $sampled(ebreak_o), $sampled(exp_ebreak));
  a_lsu_addr: assert property (@(posedge clk) disable iff (rst)
    lsu_req_o |-> lsu_addr_o == exp_addr)
    else report_mismatch("lsu_addr_o", $sampled(lsu_addr_o), $sampled(exp_addr));
  a_lsu_we: assert property (@(posedge clk) disable iff (rst)
    lsu_req_o |-> lsu_we_o == exp_we)
    else report_mismatch("lsu_we_o", $sampled(lsu_we_o), $sampled(exp_we));
  a_lsu_wdata: assert property (@(posedge clk) disable iff (rst)
    lsu_req_o && exp_we |-> lsu_wdata_o == exp_store)
    else report_mismatch("lsu_wdata_o", $sampled(lsu_wdata_o), $sampled(exp_store));
  a_req_excl: assert property (@(posedge clk) disable iff (rst) !(valid_o && lsu_req_o))
    else report_failure("valid_o was high while lsu_req_o was high");
  a_hold: assert property (@(posedge clk) disable iff (rst)
    valid_o && !next_ready_i && exp_src == SRC_FIXED |=> $stable({valid_o, rd_o,
      reg_wdata_o, redirect_o, npc_o, branch_retire_o, ebreak_o, pc_o, inst_o}))
    else report_failure("outputs changed while next_ready_i was low");
  a_ready_low: assert property (@(posedge clk) disable iff (rst)
    valid_o && !next_ready_i |-> !ready_o)
    else report_failure("ready_o was high while the result was held");

  initial begin
    next_ready_i = 1'b1;
    forever begin
      @(negedge clk);
      next_ready_i = $urandom_range(0, 3) != 0;
    end
  end

  // memory answers after 0 to 5 cycles
  initial begin
    int delay;
    lsu_rvalid_i = 1'b0;
    lsu_wready_i = 1'b0;
    lsu_rdata_i  = '0;
    forever begin
      @(negedge clk);
      lsu_rvalid_i = 1'b0;
      lsu_wready_i = 1'b0;
      if (lsu_req_o) begin
        delay = $urandom_range(0, 5);
        while (delay > 0) begin
          @(negedge clk);
          delay--;
        end
        if (lsu_we_o) begin
          mem[lsu_addr_o[7:2]] = lsu_wdata_o;
          lsu_wready_i = 1'b1;
        end else begin
          lsu_rdata_i  = mem[lsu_addr_o[7:2]];
          lsu_rvalid_i = 1'b1;
        end
      end
    end
  end

  task automatic finish_run();
    $display("run complete with %0d errors", errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  endtask

  task automatic wait_step(input bit for_handoff);
    logic [63:0] start;
    int n;
    start = for_handoff ? handoff_cnt : capture_cnt;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while ((for_handoff ? handoff_cnt : capture_cnt) == start && n < WAIT_LIMIT);
    if ((for_handoff ? handoff_cnt : capture_cnt) == start) begin
      report_failure(for_handoff ? "timeout waiting for handoff" : "timeout waiting for capture");
      finish_run();
    end
  endtask

  function automatic logic [XLEN-1:0] alu_ref(input logic [3:0] op, input logic [XLEN-1:0] a,
                                              input logic [XLEN-1:0] b);
    logic signed [XLEN-1:0] sa;
    sa = a;
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_XOR: return a ^ b;
      ALU_OR: return a | b;
      ALU_AND: return a & b;
      ALU_SLL: return a << b[4:0];
      ALU_SRL: return a >> b[4:0];
      ALU_SRA: return sa >>> b[4:0];
      ALU_SLT: return 32'($signed(a) < $signed(b));
      ALU_SLTU: return 32'(a < b);
      ALU_SLE: return 32'($signed(a) <= $signed(b));
      ALU_SLEU: return 32'(a <= b);
      default: return '0;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] csr_ref_read(input logic [11:0] addr);
    case (addr)
      CSR_MSTATUS: return m_mstatus;
      CSR_MTVEC: return m_mtvec;
      CSR_MEPC: return m_mepc;
      CSR_MCAUSE: return m_mcause;
      default: return '0;
    endcase
  endfunction

  // predicts the results, then sends one instruction and waits for its handoff
  task automatic issue(input logic [6:0] opc, input logic [2:0] f3, input logic [3:0] aop,
                       input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                       input logic [XLEN-1:0] j, input logic [XLEN-1:0] im,
                       input logic [4:0] rd, input logic sys, input logic cwen,
                       input logic ecl, input logic mrt);
    logic [XLEN-1:0] res, old, upd;
    logic taken;
    res = alu_ref(aop, a, b);
    old = csr_ref_read(im[11:0]);
    taken = (aop == ALU_SUB) ? res == '0 : (aop inside {ALU_XOR, ALU_SLT, ALU_SLTU,
      ALU_SLE, ALU_SLEU}) && res != '0;
    exp_addr   = j + im;
    exp_store  = b;
    exp_we     = opc == OP_S_TYPE;
    exp_src    = SRC_FIXED;
    exp_rd     = rd;
    exp_pc     = cur_pc;
    exp_inst   = {17'd0, f3, rd, opc};
    exp_ebreak = sys && !cwen && !ecl && !mrt;
    if (opc == OP_IL_TYPE) exp_fixed = ref_mem[exp_addr[7:2]];
    else if (sys) exp_fixed = old;
    else exp_fixed = res;
    if (rd == 5'd0) exp_fixed = '0;
    if (sys && rd != 5'd0) begin
      case (im[11:0])
        CSR_MCYCLE: exp_src = SRC_CYC_LO;
        CSR_MCYCLEH: exp_src = SRC_CYC_HI;
        CSR_MINSTRET: exp_src = SRC_RET_LO;
        CSR_MINSTRETH: exp_src = SRC_RET_HI;
        default: exp_src = SRC_FIXED;
      endcase
    end
    exp_redirect = opc == OP_JAL || opc == OP_JALR || ecl || mrt || (opc == OP_B_TYPE && taken);
    exp_npc      = ecl ? m_mtvec : (mrt ? m_mepc : exp_addr);
    exp_retire   = sys || opc == OP_B_TYPE || opc == OP_IL_TYPE;
    if (exp_we) ref_mem[exp_addr[7:2]] = b;
    if (ecl) begin
      m_mepc       = cur_pc;
      m_mcause     = 32'd11;
      m_mstatus[7] = m_mstatus[3];
      m_mstatus[3] = 1'b0;
    end else if (mrt) begin
      m_mstatus[3] = m_mstatus[7];
      m_mstatus[7] = 1'b1;
    end else if (cwen) begin
      case (f3)
        F3_CSRRW, F3_CSRRWI: upd = a;
        F3_CSRRS, F3_CSRRSI: upd = old | a;
        F3_CSRRC, F3_CSRRCI: upd = old & ~a;
        default: upd = old;
      endcase
      case (im[11:0])
        CSR_MSTATUS: m_mstatus = upd;
        CSR_MTVEC: m_mtvec = upd;
        CSR_MEPC: m_mepc = upd;
        CSR_MCAUSE: m_mcause = upd;
        default: ;
      endcase
    end
    inst_i       = exp_inst;
    {pc_i, alu_op_i, op1_i, op2_i, opj_i, imm_i, rd_i} = {cur_pc, aop, a, b, j, im, rd};
    {ren_i, wen_i} = {opc == OP_IL_TYPE, opc == OP_S_TYPE};
    {system_i, csr_wen_i, ecall_i, mret_i, ebreak_i} = {sys, cwen, ecl, mrt, exp_ebreak};
    prev_valid_i = 1'b1;
    wait_step(1'b0);
    prev_valid_i = 1'b0;
    wait_step(1'b1);
    cur_pc = exp_redirect ? exp_npc : cur_pc + 4;
  endtask

  task automatic csr_op(input logic [2:0] f3, input logic [11:0] addr,
                        input logic [XLEN-1:0] src, input logic [4:0] rd);
    issue(OP_SYSTEM, f3, ALU_ADD, src, '0, '0, {20'd0, addr}, rd, 1'b1, 1'b1, 1'b0, 1'b0);
  endtask

  initial begin
    logic [XLEN-1:0] a, b;
    logic [2:0] f3;
    void'($urandom(49166));
    rst = 1'b1;
    {inst_i, pc_i, imm_i, op1_i, op2_i, opj_i, alu_op_i, rd_i, ren_i, wen_i, system_i,
     csr_wen_i, ecall_i, mret_i, ebreak_i, prev_valid_i} = '0;
    {m_mstatus, m_mepc, m_mcause, exp_fixed, exp_src} = '0;
    m_mtvec = MTVEC_INIT;
    cur_pc  = 32'h0000_1000;
    for (int i = 0; i < 64; i++) begin
      mem[i]     = 32'h9E37_79B9 * (i + 1);
      ref_mem[i] = 32'h9E37_79B9 * (i + 1);
    end
    repeat (2) @(negedge clk);
    rst = 1'b0;
    assert (ready_o && !valid_o && !lsu_req_o)
      else report_failure("outputs not idle after reset");

    // every alu op, register and immediate forms
    for (int k = 0; k < 12; k++) begin
      for (int n = 0; n < 6; n++) begin
        a = $urandom;
        b = (n == 2) ? a : $urandom;
        if (n[0]) b = {{20{b[11]}}, b[11:0]};
        issue(n[0] ? OP_I_TYPE : OP_R_TYPE, 3'd0, 4'(k), a, b, '0, n[0] ? b : '0,
              (n == 5) ? 5'd0 : 5'($urandom_range(1, 31)), 1'b0, 1'b0, 1'b0, 1'b0);
      end
    end

    // branches on each compare op, then jumps
    for (int k = 0; k < 6; k++) begin
      for (int n = 0; n < 4; n++) begin
        a = $urandom;
        b = n[0] ? a : $urandom;
        issue(OP_B_TYPE, 3'd0, BR_OPS[k], a, b, cur_pc, 32'($urandom_range(0, 255)) << 2,
              5'd0, 1'b0, 1'b0, 1'b0, 1'b0);
      end
      issue(OP_JAL, 3'd0, ALU_ADD, cur_pc, 32'd4, cur_pc, 32'($urandom_range(0, 255)) << 2,
            5'($urandom_range(0, 31)), 1'b0, 1'b0, 1'b0, 1'b0);
      issue(OP_JALR, 3'd0, ALU_ADD, cur_pc, 32'd4, $urandom & ~32'h3, 32'd16,
            5'($urandom_range(0, 31)), 1'b0, 1'b0, 1'b0, 1'b0);
    end

    // store then load back through the same address
    for (int n = 0; n < 10; n++) begin
      a = 32'($urandom_range(0, 31)) << 2;
      b = 32'($urandom_range(0, 31)) << 2;
      issue(OP_S_TYPE, 3'd2, ALU_ADD, '0, $urandom, a, b, 5'd0, 1'b0, 1'b0, 1'b0, 1'b0);
      issue(OP_IL_TYPE, 3'd2, ALU_ADD, '0, '0, a, b, 5'($urandom_range(1, 31)),
            1'b0, 1'b0, 1'b0, 1'b0);
    end

    // zimm forms carry a 5-bit source
    for (int n = 0; n < 24; n++) begin
      f3 = CSR_F3S[$urandom_range(0, 5)];
      csr_op(f3, CSR_ADDRS[$urandom_range(0, 7)],
             f3[2] ? 32'($urandom_range(0, 31)) : $urandom, 5'($urandom_range(0, 31)));
    end

    // trap entry and return with MIE set
    csr_op(F3_CSRRSI, CSR_MSTATUS, 32'd8, 5'd0);
    issue(OP_SYSTEM, 3'd0, ALU_ADD, '0, '0, '0, '0, 5'd0, 1'b1, 1'b0, 1'b1, 1'b0);
    csr_op(F3_CSRRS, CSR_MEPC, '0, 5'd10);
    csr_op(F3_CSRRS, CSR_MCAUSE, '0, 5'd11);
    csr_op(F3_CSRRS, CSR_MSTATUS, '0, 5'd12);
    issue(OP_SYSTEM, 3'd0, ALU_ADD, '0, '0, '0, 32'h302, 5'd0, 1'b1, 1'b0, 1'b0, 1'b1);
    // ebreak only passes through to the next stage
    issue(OP_SYSTEM, 3'd0, ALU_ADD, '0, '0, '0, 32'h001, 5'd0, 1'b1, 1'b0, 1'b0, 1'b0);
    csr_op(F3_CSRRS, CSR_MSTATUS, '0, 5'd12);
    csr_op(F3_CSRRS, CSR_MINSTRET, '0, 5'd13);
    finish_run();
  end

endmodule

// File: source/exu_top.sv
`timescale 1ns/1ps

module exu_top import exu_pkg::*; #(
  parameter int              CNT_W       = 64,
  parameter logic [XLEN-1:0] MTVEC_RESET = 32'h0000_0100
) (
  input  logic            clk,
  input  logic            rst,
  input  logic [31:0]     inst_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [XLEN-1:0] imm_i,
  input  logic [XLEN-1:0] op1_i,
  input  logic [XLEN-1:0] op2_i,
  input  logic [XLEN-1:0] opj_i,
  input  logic [3:0]      alu_op_i,
  input  logic [4:0]      rd_i,
  input  logic            ren_i,
  input  logic            wen_i,
  input  logic            system_i,
  input  logic            csr_wen_i,
  input  logic            ecall_i,
  input  logic            mret_i,
  input  logic            ebreak_i,
  input  logic            prev_valid_i,
  output logic            ready_o,
  output logic            valid_o,
  output logic [4:0]      rd_o,
  output logic [XLEN-1:0] reg_wdata_o,
  output logic            redirect_o,
  output logic [XLEN-1:0] npc_o,
  output logic            branch_retire_o,
  output logic            ebreak_o,
  output logic [XLEN-1:0] pc_o,
  output logic [31:0]     inst_o,
  input  logic            next_ready_i,
  output logic            lsu_req_o,
  output logic            lsu_we_o,
  output logic [XLEN-1:0] lsu_addr_o,
  output logic [XLEN-1:0] lsu_wdata_o,
  input  logic [XLEN-1:0] lsu_rdata_i,
  input  logic            lsu_rvalid_i,
  input  logic            lsu_wready_i
);

  logic [31:0]     inst_q;
  logic [XLEN-1:0] pc_q, imm_q, op1_q, op2_q, opj_q, load_q;
  logic [3:0]      alu_op_q;
  logic [4:0]      rd_q;
  logic            ren_q, wen_q, system_q, csr_wen_q, ecall_q, mret_q, ebreak_q;
  logic            capture, commit, redirect;
  logic [XLEN-1:0] addr, alu_res, csr_rdata, csr_wdata, mtvec, mepc;
  logic [CNT_W-1:0] cycle, instret;
  logic [6:0]      opcode;
  logic [2:0]      funct3;

  always_ff @(posedge clk) begin
    if (capture) begin
      inst_q    <= inst_i;
      pc_q      <= pc_i;
      imm_q     <= imm_i;
      op1_q     <= op1_i;
      op2_q     <= op2_i;
      opj_q     <= opj_i;
      alu_op_q  <= alu_op_i;
      rd_q      <= rd_i;
      ren_q     <= ren_i;
      wen_q     <= wen_i;
      system_q  <= system_i;
      csr_wen_q <= csr_wen_i;
      ecall_q   <= ecall_i;
      mret_q    <= mret_i;
      ebreak_q  <= ebreak_i;
    end
    if (lsu_rvalid_i && lsu_req_o) begin
      load_q <= lsu_rdata_i;
    end
  end

  assign opcode = inst_q[6:0];
  assign funct3 = inst_q[14:12];
  assign addr   = opj_q + imm_q;

  exu_ctrl_fsm exu_ctrl_fsm_inst (
    .clk(clk), .rst(rst), .prev_valid_i(prev_valid_i), .next_ready_i(next_ready_i),
    .is_mem_i(ren_q | wen_q), .lsu_rvalid_i(lsu_rvalid_i), .lsu_wready_i(lsu_wready_i),
    .ready_o(ready_o), .capture_o(capture), .mem_req_o(lsu_req_o), .valid_o(valid_o),
    .commit_o(commit)
  );

  exu_alu exu_alu_inst (.src1_i(op1_q), .src2_i(op2_q), .alu_op_i(alu_op_q), .res_o(alu_res));

  exu_branch_sys exu_branch_sys_inst (
    .opcode_i(opcode), .funct3_i(funct3), .alu_op_i(alu_op_q), .alu_res_i(alu_res),
    .addr_i(addr), .pc_i(pc_q), .src1_i(op1_q), .csr_rdata_i(csr_rdata), .ecall_i(ecall_q),
    .mret_i(mret_q), .system_i(system_q), .mtvec_i(mtvec), .mepc_i(mepc),
    .redirect_o(redirect), .npc_o(npc_o), .csr_wdata_o(csr_wdata),
    .branch_retire_o(branch_retire_o)
  );

  // csr address sits in the low immediate bits
  exu_csr #(.CNT_W(CNT_W), .MTVEC_RESET(MTVEC_RESET)) exu_csr_inst (
    .clk(clk), .rst(rst), .commit_i(commit), .csr_wen_i(csr_wen_q), .ecall_i(ecall_q),
    .mret_i(mret_q), .addr_i(imm_q[11:0]), .wdata_i(csr_wdata), .pc_i(pc_q),
    .cycle_i(cycle), .instret_i(instret), .rdata_o(csr_rdata), .mtvec_o(mtvec),
    .mepc_o(mepc)
  );

  exu_perf_counter #(.CNT_W(CNT_W)) exu_perf_counter_inst (
    .clk(clk), .rst(rst), .retire_i(commit), .cycle_o(cycle), .instret_o(instret)
  );

  // x0 never sees a value
  assign reg_wdata_o = {XLEN{rd_q != 5'd0}} &
    ((opcode == OP_IL_TYPE) ? load_q : system_q ? csr_rdata : alu_res);

  assign redirect_o  = redirect & valid_o;
  assign rd_o        = rd_q;
  assign ebreak_o    = ebreak_q;
  assign pc_o        = pc_q;
  assign inst_o      = inst_q;
  assign lsu_we_o    = wen_q;
  assign lsu_addr_o  = addr;
  assign lsu_wdata_o = op2_q;

endmodule

// File: source/exu_ctrl_fsm.sv
`timescale 1ns/1ps

module exu_ctrl_fsm import exu_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic prev_valid_i,
  input  logic next_ready_i,
  input  logic is_mem_i,
  input  logic lsu_rvalid_i,
  input  logic lsu_wready_i,
  output logic ready_o,
  output logic capture_o,
  output logic mem_req_o,
  output logic valid_o,
  output logic commit_o
);

  exu_state_t state_q;
  exu_state_t state_d;
  logic       lsu_resp;

  assign lsu_resp = lsu_rvalid_i | lsu_wready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: if (prev_valid_i) state_d = EXEC;
      EXEC: state_d = is_mem_i ? MEM_WAIT : DONE;
      // responses outside MEM_WAIT are dropped
      MEM_WAIT: if (lsu_resp) state_d = DONE;
      DONE: if (next_ready_i) state_d = prev_valid_i ? EXEC : IDLE;
      default: state_d = IDLE;
    endcase
  end

  assign valid_o   = state_q == DONE;
  assign mem_req_o = state_q == MEM_WAIT;
  // accept again in the handoff cycle
  assign ready_o   = (state_q == IDLE) | (valid_o & next_ready_i);
  assign capture_o = prev_valid_i & ready_o;
  assign commit_o  = valid_o & next_ready_i;

  a_no_early_valid: assert property (@(posedge clk) disable iff (rst)
    mem_req_o && !lsu_resp |=> !valid_o);

  a_valid_hold: assert property (@(posedge clk) disable iff (rst)
    valid_o && !next_ready_i |=> valid_o);

endmodule

// File: source/exu_perf_counter.sv
`timescale 1ns/1ps

module exu_perf_counter #(
  parameter int CNT_W = 64
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             retire_i,
  output logic [CNT_W-1:0] cycle_o,
  output logic [CNT_W-1:0] instret_o
);

  always_ff @(posedge clk) begin
    if (rst) begin
      cycle_o   <= '0;
      instret_o <= '0;
    end else begin
      cycle_o <= cycle_o + 1'b1;
      if (retire_i) begin
        instret_o <= instret_o + 1'b1;
      end
    end
  end

endmodule

// File: source/exu_csr.sv
`timescale 1ns/1ps

module exu_csr import exu_pkg::*; #(
  parameter int              CNT_W       = 64,
  parameter logic [XLEN-1:0] MTVEC_RESET = '0
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             commit_i,
  input  logic             csr_wen_i,
  input  logic             ecall_i,
  input  logic             mret_i,
  input  logic [11:0]      addr_i,
  input  logic [XLEN-1:0]  wdata_i,
  input  logic [XLEN-1:0]  pc_i,
  input  logic [CNT_W-1:0] cycle_i,
  input  logic [CNT_W-1:0] instret_i,
  output logic [XLEN-1:0]  rdata_o,
  output logic [XLEN-1:0]  mtvec_o,
  output logic [XLEN-1:0]  mepc_o
);

  mstatus_u        mstatus_q;
  logic [XLEN-1:0] mtvec_q;
  logic [XLEN-1:0] mepc_q;
  logic [XLEN-1:0] mcause_q;
  logic [63:0]     cycle_w;
  logic [63:0]     instret_w;

  // high halves read zero for a 32-bit counter
  assign cycle_w   = 64'(cycle_i);
  assign instret_w = 64'(instret_i);

  always_comb begin
    case (addr_i)
      CSR_MSTATUS: rdata_o = mstatus_q.raw;
      CSR_MTVEC: rdata_o = mtvec_q;
      CSR_MEPC: rdata_o = mepc_q;
      CSR_MCAUSE: rdata_o = mcause_q;
      CSR_MCYCLE: rdata_o = cycle_w[31:0];
      CSR_MCYCLEH: rdata_o = cycle_w[63:32];
      CSR_MINSTRET: rdata_o = instret_w[31:0];
      CSR_MINSTRETH: rdata_o = instret_w[63:32];
      default: rdata_o = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q.raw <= '0;
      mtvec_q       <= MTVEC_RESET;
      mepc_q        <= '0;
      mcause_q      <= '0;
    end else if (commit_i) begin
      if (ecall_i) begin
        mepc_q              <= wdata_i;
        mcause_q            <= CAUSE_ECALL_M;
        mstatus_q.f.mpie    <= mstatus_q.f.mie;
        mstatus_q.f.mie     <= 1'b0;
      end else if (mret_i) begin
        mstatus_q.f.mie  <= mstatus_q.f.mpie;
        mstatus_q.f.mpie <= 1'b1;
      end else if (csr_wen_i) begin
        // counters are read only here
        case (addr_i)
          CSR_MSTATUS: mstatus_q.raw <= wdata_i;
          CSR_MTVEC: mtvec_q <= wdata_i;
          CSR_MEPC: mepc_q <= wdata_i;
          CSR_MCAUSE: mcause_q <= wdata_i;
          default: ;
        endcase
      end
    end
  end

  assign mtvec_o = mtvec_q;
  assign mepc_o  = mepc_q;

  a_trap_excl: assert property (@(posedge clk) disable iff (rst) !(ecall_i && mret_i));

endmodule

// File: source/exu_branch_sys.sv
`timescale 1ns/1ps

module exu_branch_sys import exu_pkg::*; (
  input  logic [6:0]      opcode_i,
  input  logic [2:0]      funct3_i,
  input  logic [3:0]      alu_op_i,
  input  logic [XLEN-1:0] alu_res_i,
  input  logic [XLEN-1:0] addr_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [XLEN-1:0] src1_i,
  input  logic [XLEN-1:0] csr_rdata_i,
  input  logic            ecall_i,
  input  logic            mret_i,
  input  logic            system_i,
  input  logic [XLEN-1:0] mtvec_i,
  input  logic [XLEN-1:0] mepc_i,
  output logic            redirect_o,
  output logic [XLEN-1:0] npc_o,
  output logic [XLEN-1:0] csr_wdata_o,
  output logic            branch_retire_o
);

  logic            taken;
  logic            is_jump;
  logic [XLEN-1:0] csr_rmw;

  // decode maps each branch onto a compare op
  always_comb begin
    case (alu_op_i)
      ALU_SUB: taken = ~|alu_res_i;
      ALU_XOR, ALU_SLT, ALU_SLTU, ALU_SLE, ALU_SLEU: taken = |alu_res_i;
      default: taken = 1'b0;
    endcase
  end

  assign is_jump    = (opcode_i == OP_JAL) | (opcode_i == OP_JALR);
  assign redirect_o = is_jump | ecall_i | mret_i | ((opcode_i == OP_B_TYPE) & taken);

  assign npc_o = ecall_i ? mtvec_i : mret_i ? mepc_i : addr_i;

  // src1 already holds rs1 or zimm
  always_comb begin
    case (funct3_i)
      F3_CSRRW, F3_CSRRWI: csr_rmw = src1_i;
      F3_CSRRS, F3_CSRRSI: csr_rmw = csr_rdata_i | src1_i;
      F3_CSRRC, F3_CSRRCI: csr_rmw = csr_rdata_i & ~src1_i;
      default: csr_rmw = csr_rdata_i;
    endcase
  end

  // on ecall the write data carries the trap pc for mepc
  assign csr_wdata_o = ecall_i ? pc_i : (system_i ? csr_rmw : '0);

  assign branch_retire_o = system_i | (opcode_i == OP_B_TYPE) | (opcode_i == OP_IL_TYPE);

endmodule

// File: source/exu_alu.sv
`timescale 1ns/1ps

module exu_alu import exu_pkg::*; (
  input  logic [XLEN-1:0] src1_i,
  input  logic [XLEN-1:0] src2_i,
  input  logic [3:0]      alu_op_i,
  output logic [XLEN-1:0] res_o
);

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;
  logic       eq;

  assign shamt = src2_i[4:0];
  assign lt_s  = $signed(src1_i) < $signed(src2_i);
  assign lt_u  = src1_i < src2_i;
  assign eq    = src1_i == src2_i;

  always_comb begin
    case (alu_op_i)
      ALU_ADD: res_o = src1_i + src2_i;
      ALU_SUB: res_o = src1_i - src2_i;
      ALU_XOR: res_o = src1_i ^ src2_i;
      ALU_OR: res_o = src1_i | src2_i;
      ALU_AND: res_o = src1_i & src2_i;
      ALU_SLL: res_o = src1_i << shamt;
      ALU_SRL: res_o = src1_i >> shamt;
      ALU_SRA: res_o = $unsigned($signed(src1_i) >>> shamt);
      // compares give 0 or 1
      ALU_SLT: res_o = {{(XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: res_o = {{(XLEN-1){1'b0}}, lt_u};
      ALU_SLE: res_o = {{(XLEN-1){1'b0}}, lt_s | eq};
      ALU_SLEU: res_o = {{(XLEN-1){1'b0}}, lt_u | eq};
      default: res_o = '0;
    endcase
  end

endmodule

// File: source/exu_pkg.sv
package exu_pkg;

  localparam int XLEN = 32;

  // base opcodes
  localparam logic [6:0] OP_LUI     = 7'b0110111;
  localparam logic [6:0] OP_AUIPC   = 7'b0010111;
  localparam logic [6:0] OP_JAL     = 7'b1101111;
  localparam logic [6:0] OP_JALR    = 7'b1100111;
  localparam logic [6:0] OP_B_TYPE  = 7'b1100011;
  localparam logic [6:0] OP_IL_TYPE = 7'b0000011;
  localparam logic [6:0] OP_S_TYPE  = 7'b0100011;
  localparam logic [6:0] OP_I_TYPE  = 7'b0010011;
  localparam logic [6:0] OP_R_TYPE  = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM  = 7'b1110011;

  // zicsr funct3
  localparam logic [2:0] F3_CSRRW  = 3'b001;
  localparam logic [2:0] F3_CSRRS  = 3'b010;
  localparam logic [2:0] F3_CSRRC  = 3'b011;
  localparam logic [2:0] F3_CSRRWI = 3'b101;
  localparam logic [2:0] F3_CSRRSI = 3'b110;
  localparam logic [2:0] F3_CSRRCI = 3'b111;

  localparam logic [3:0] ALU_ADD  = 4'd0;
  localparam logic [3:0] ALU_SUB  = 4'd1;
  localparam logic [3:0] ALU_XOR  = 4'd2;
  localparam logic [3:0] ALU_OR   = 4'd3;
  localparam logic [3:0] ALU_AND  = 4'd4;
  localparam logic [3:0] ALU_SLL  = 4'd5;
  localparam logic [3:0] ALU_SRL  = 4'd6;
  localparam logic [3:0] ALU_SRA  = 4'd7;
  localparam logic [3:0] ALU_SLT  = 4'd8;
  localparam logic [3:0] ALU_SLTU = 4'd9;
  localparam logic [3:0] ALU_SLE  = 4'd10;
  localparam logic [3:0] ALU_SLEU = 4'd11;

  localparam logic [11:0] CSR_MSTATUS   = 12'h300;
  localparam logic [11:0] CSR_MTVEC     = 12'h305;
  localparam logic [11:0] CSR_MEPC      = 12'h341;
  localparam logic [11:0] CSR_MCAUSE    = 12'h342;
  localparam logic [11:0] CSR_MCYCLE    = 12'hB00;
  localparam logic [11:0] CSR_MINSTRET  = 12'hB02;
  localparam logic [11:0] CSR_MCYCLEH   = 12'hB80;
  localparam logic [11:0] CSR_MINSTRETH = 12'hB82;

  localparam logic [XLEN-1:0] CAUSE_ECALL_M = 32'd11;

  typedef enum logic [1:0] {IDLE, EXEC, MEM_WAIT, DONE} exu_state_t;

  typedef struct packed {
    logic [18:0] rsvd_31_13;
    logic [1:0]  mpp;
    logic [2:0]  rsvd_10_8;
    logic        mpie;
    logic [2:0]  rsvd_6_4;
    logic        mie;
    logic [2:0]  rsvd_2_0;
  } mstatus_f_t;

  // raw word for csr access, fields for trap entry and mret
  typedef union packed {
    logic [XLEN-1:0] raw;
    mstatus_f_t      f;
  } mstatus_u;

endpackage
